//--- compile.f
+incdir+bench
hw/ctrlPkg.sv
hw/instDecoder.sv
hw/branchResolver.sv
hw/excPrioritizer.sv
hw/ctrlTop.sv
bench/ctrlTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert
TOP      = ctrlTb
FILELIST = compile.f
LOG      = sim.log
FAILMSG  = === FAIL ===
PASSMSG  = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG) || (echo "Simulation ended early"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

logic [31:0] lfsr;

// Entries are {op, funct} for SPECIAL, {op, 0, rt} for REGIMM, {op, 0} otherwise
localparam logic [11:0] WbList [0:43] = '{
	{OpRType, FnAdd}, {OpRType, FnAddu}, {OpRType, FnSub}, {OpRType, FnSubu},
	{OpRType, FnAnd}, {OpRType, FnOr}, {OpRType, FnXor}, {OpRType, FnNor},
	{OpRType, FnSlt}, {OpRType, FnSltu}, {OpRType, FnSll}, {OpRType, FnSrl},
	{OpRType, FnSra}, {OpRType, FnSllv}, {OpRType, FnSrlv}, {OpRType, FnSrav},
	{OpRType, FnMfhi}, {OpRType, FnMflo}, {OpRType, FnMthi}, {OpRType, FnMtlo},
	{OpRType, FnMult}, {OpRType, FnMultu}, {OpRType, FnDiv}, {OpRType, FnDivu},
	{OpAddi, 6'd0}, {OpAddiu, 6'd0}, {OpSlti, 6'd0}, {OpSltiu, 6'd0},
	{OpAndi, 6'd0}, {OpOri, 6'd0}, {OpXori, 6'd0}, {OpLui, 6'd0},
	{OpLb, 6'd0}, {OpLbu, 6'd0}, {OpLh, 6'd0}, {OpLhu, 6'd0},
	{OpLwl, 6'd0}, {OpLwr, 6'd0}, {OpLw, 6'd0}, {OpSb, 6'd0},
	{OpSh, 6'd0}, {OpSwl, 6'd0}, {OpSw, 6'd0}, {OpSwr, 6'd0}
};

localparam logic [11:0] BrList [0:19] = '{
	{OpBeq, 6'd0}, {OpBne, 6'd0}, {OpBlez, 6'd0}, {OpBgtz, 6'd0},
	{OpBeql, 6'd0}, {OpBnel, 6'd0}, {OpBlezl, 6'd0}, {OpBgtzl, 6'd0},
	{OpJ, 6'd0}, {OpJal, 6'd0}, {OpRType, FnJr}, {OpRType, FnJalr},
	{OpRegImm, 1'b0, RtBltz}, {OpRegImm, 1'b0, RtBgez}, {OpRegImm, 1'b0, RtBltzl},
	{OpRegImm, 1'b0, RtBgezl}, {OpRegImm, 1'b0, RtBltzal}, {OpRegImm, 1'b0, RtBgezal},
	{OpRegImm, 1'b0, RtBltzall}, {OpRegImm, 1'b0, RtBgezall}
};

localparam logic [11:0] MoveList [0:1] = '{{OpRType, FnMovz}, {OpRType, FnMovn}};
localparam logic [11:0] ExcList [0:1] = '{{OpRType, FnBreak}, {OpRType, FnSyscall}};

// One LFSR step per bit, new bits shift in at the bottom
function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	int i;
	v = '0;
	for (i = 0; i < n; i++) begin
		v = {v[30:0], lfsr[0]};
		lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
	end
	return v;
endfunction

function automatic cmpFlagsT makeFlags();
	cmpFlagsT f;
	logic [31:0] b;
	b = randBits(3);
	f.rsEqRt = b[0];
	f.rsSign = (b[2:1] == 2'd3) ? SignNeg : cmpSignT'(b[2:1]);
	return f;
endfunction

function automatic logic [31:0] makeInst(input int grp);
	logic [31:0] w;
	logic [31:0] pick;
	logic [11:0] e;
	w = randBits(32);
	if (randBits(3) == 32'd0)
		return w;  // Unconstrained word
	pick = randBits(6);
	case (grp)
		0:       e = WbList[6'(pick % 32'd44)];
		1:       e = BrList[5'(pick % 32'd20)];
		2:       e = MoveList[pick[0]];
		default: e = ExcList[pick[0]];
	endcase
	w[31:26] = e[11:6];
	if (e[11:6] == OpRType)
		w[5:0] = e[5:0];
	else if (e[11:6] == OpRegImm)
		w[20:16] = e[4:0];
	return w;
endfunction

function automatic memSelT memWidth(input logic [5:0] op);
	case (op)
		OpLb, OpSb:   return MemByte;
		OpLbu:        return MemByteU;
		OpLh, OpSh:   return MemHalf;
		OpLhu:        return MemHalfU;
		OpLwl, OpSwl: return MemWordLeft;
		OpLwr, OpSwr: return MemWordRight;
		default:      return MemWord;
	endcase
endfunction

function automatic resultT modelResult(input logic [31:0] w, input cmpFlagsT c);
	resultT r;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rt;
	aluOpT alu;
	brTypeT br;
	npcOpT jt;
	logic likely;
	logic link;
	logic ri;
	logic bp;
	logic sys;
	logic taken;
	op = w[31:26];
	fn = w[5:0];
	rt = w[20:16];
	r = '0;
	r.ctrl.aluOp = AluNone;
	r.ctrl.wbSel = WbAlu;
	r.moveCommit = 1'b1;
	alu = AluNone;
	br = BrNone;
	jt = NpcSeq;
	likely = 1'b0;
	link = 1'b0;
	ri = 1'b0;
	bp = 1'b0;
	sys = 1'b0;
	case (op)
		OpRType: begin
			r.ctrl.dstSel = DstRd;
			case (fn)
				FnAdd:  alu = AluAdd;
				FnAddu: alu = AluAddu;
				FnSub:  alu = AluSub;
				FnSubu: alu = AluSubu;
				FnAnd:  alu = AluAnd;
				FnOr:   alu = AluOr;
				FnXor:  alu = AluXor;
				FnNor:  alu = AluNor;
				FnSlt:  alu = AluSlt;
				FnSltu: alu = AluSltu;
				FnSll, FnSllv: alu = AluSll;
				FnSrl, FnSrlv: alu = AluSrl;
				FnSra, FnSrav: alu = AluSra;
				FnMovz, FnMovn: begin
					alu = AluMov;
					// Flag holds rt == 0 for moves
					r.moveCommit = (fn == FnMovz) ? c.rsEqRt : !c.rsEqRt;
				end
				FnJr: jt = NpcJumpReg;
				FnJalr: begin
					jt = NpcJumpReg;
					r.ctrl.rfWr = 1'b1;
					r.ctrl.wbSel = WbLink;
				end
				FnMfhi, FnMflo: begin
					r.ctrl.rfWr = 1'b1;
					r.ctrl.wbSel = WbHilo;
					r.ctrl.hiSel = (fn == FnMfhi);
				end
				FnMthi, FnMtlo: begin
					r.ctrl.hiloWr = 1'b1;
					r.ctrl.hiSel = (fn == FnMthi);
				end
				FnMult, FnMultu, FnDiv, FnDivu: begin
					r.ctrl.hiloWr = 1'b1;
					r.ctrl.mdStart = 1'b1;
				end
				FnBreak:   bp = 1'b1;
				FnSyscall: sys = 1'b1;
				default:   ri = 1'b1;
			endcase
			r.ctrl.shamtSel = (fn == FnSll || fn == FnSrl || fn == FnSra);
		end
		OpRegImm: begin
			case (rt)
				RtBltz, RtBltzl, RtBltzal, RtBltzall: br = BrLtz;
				RtBgez, RtBgezl, RtBgezal, RtBgezall: br = BrGez;
				default: ri = 1'b1;
			endcase
			likely = (rt == RtBltzl || rt == RtBgezl || rt == RtBltzall || rt == RtBgezall);
			link = (rt == RtBltzal || rt == RtBgezal || rt == RtBltzall || rt == RtBgezall);
		end
		OpJ: jt = NpcJump;
		OpJal: begin
			jt = NpcJump;
			link = 1'b1;
		end
		OpBeq, OpBeql:   br = BrEq;
		OpBne, OpBnel:   br = BrNe;
		OpBlez, OpBlezl: br = BrLez;
		OpBgtz, OpBgtzl: br = BrGtz;
		OpAddi:  alu = AluAdd;
		OpAddiu: alu = AluAddu;
		OpSlti:  alu = AluSlt;
		OpSltiu: alu = AluSltu;
		OpAndi:  alu = AluAnd;
		OpOri:   alu = AluOr;
		OpXori:  alu = AluXor;
		OpLui: begin
			r.ctrl.rfWr = 1'b1;
			r.ctrl.extOp = ExtUpper;
			r.ctrl.wbSel = WbImm;
		end
		OpLb, OpLbu, OpLh, OpLhu, OpLwl, OpLwr, OpLw: begin
			r.ctrl.dmRd = 1'b1;
			r.ctrl.rfWr = 1'b1;
		end
		OpSb, OpSh, OpSwl, OpSw, OpSwr: r.ctrl.dmWr = 1'b1;
		default: ri = 1'b1;
	endcase
	if (op == OpBeql || op == OpBnel || op == OpBlezl || op == OpBgtzl)
		likely = 1'b1;
	// Arithmetic immediates sign-extend, logical ones zero-extend
	if (op == OpAddi || op == OpAddiu || op == OpSlti || op == OpSltiu)
		r.ctrl.extOp = ExtSign;
	if (link) begin
		r.ctrl.rfWr = 1'b1;
		r.ctrl.dstSel = DstRa;  // Register 31
		r.ctrl.wbSel = WbLink;
	end
	if (alu != AluNone) begin
		r.ctrl.rfWr = 1'b1;
		r.ctrl.aluOp = alu;
	end
	if (r.ctrl.dmRd || r.ctrl.dmWr) begin
		r.ctrl.aluOp = AluAdd;  // Base plus offset
		r.ctrl.extOp = ExtSign;
		r.ctrl.wbSel = WbMem;
		r.ctrl.memSel = memWidth(op);
	end
	case (br)
		BrEq:    taken = c.rsEqRt;
		BrNe:    taken = !c.rsEqRt;
		BrGez:   taken = (c.rsSign != SignNeg);
		BrLtz:   taken = (c.rsSign == SignNeg);
		BrLez:   taken = (c.rsSign != SignPos);
		BrGtz:   taken = (c.rsSign == SignPos);
		default: taken = 1'b0;
	endcase
	r.npcOp = taken ? NpcBranch : jt;
	r.branchFlush = likely && !taken;
	if (ri || bp || sys) begin
		r.exception = 1'b1;
		r.excCode = ri ? ExcRi : (bp ? ExcBp : ExcSys);
		r.ctrl.rfWr = 1'b0;
		r.ctrl.dmWr = 1'b0;
		r.ctrl.hiloWr = 1'b0;
		r.ctrl.mdStart = 1'b0;
		r.branchFlush = 1'b0;
		r.npcOp = NpcSeq;
	end
	return r;
endfunction

`endif

//--- bench/ctrlTb.sv
`timescale 1ns/1ns

module ctrlTb;
	import ctrlPkg::*;

	logic        clk;
	logic        rst;
	logic        instValid;
	instT        inst;
	cmpFlagsT    cmp;
	resultT      result;
	logic        outValid;

	logic        rstLevel;    // Level driven onto rst each cycle
	logic [1:0]  strobeHist;  // [0] one cycle back, [1] two cycles back
	resultT      expQ[$];
	logic [31:0] wordQ[$];
	string       testName;
	int          checkCount;
	int          errCount;

	`include "ctrlModel.svh"

	ctrlTop ctrlTop_inst (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.inst      (inst),
		.cmp       (cmp),
		.result    (result),
		.outValid  (outValid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Drive one cycle, then check the outputs at mid-cycle
	task automatic runCycle(input logic v, input logic [31:0] word, input cmpFlagsT flags);
		resultT exp;
		logic [31:0] expWord;
		logic live;
		@(posedge clk);
		#2;
		live = v && rstLevel;
		rst = rstLevel;
		instValid = v;
		inst = word;
		cmp = flags;
		if (live) begin
			expQ.push_back(modelResult(word, flags));
			wordQ.push_back(word);
		end
		#18;
		if (strobeHist[1] && !outValid) begin
			$display("test %s: outValid missing two cycles after a strobe", testName);
			errCount++;
			if (expQ.size() != 0) begin
				exp = expQ.pop_front();
				expWord = wordQ.pop_front();
			end
		end else if (!strobeHist[1] && outValid) begin
			$display("test %s: outValid high without a strobe two cycles before", testName);
			errCount++;
		end
		if (outValid) begin
			if (expQ.size() == 0) begin
				$display("test %s: outValid with no expected result queued", testName);
				errCount++;
			end else begin
				exp = expQ.pop_front();
				expWord = wordQ.pop_front();
				checkCount++;
				if (result !== exp) begin
					$display("mismatch test=%s inst=%h expected=%h actual=%h",
						testName, expWord, exp, result);
					errCount++;
				end
			end
		end else if (result.ctrl.rfWr || result.ctrl.dmWr || result.ctrl.dmRd ||
			result.ctrl.hiloWr || result.ctrl.mdStart || result.exception ||
			result.branchFlush) begin
			$display("test %s: write enable or exception set while outValid is low", testName);
			errCount++;
		end
		strobeHist = {strobeHist[0], live};
	endtask

	task automatic drainQueue();
		int n;
		n = 0;
		while ((expQ.size() != 0 || strobeHist != 2'b00) && n < 8) begin
			runCycle(1'b0, 32'h0, '0);
			n++;
		end
		if (expQ.size() != 0) begin
			$display("test %s: timed out waiting for %0d results", testName, expQ.size());
			errCount++;
			expQ.delete();
			wordQ.delete();
		end
	endtask

	task automatic reportTest(input int startChk, input int startErr);
		$display("test %s: %0d results checked, %0d errors", testName,
			checkCount - startChk, errCount - startErr);
	endtask

	task automatic resetIdle();
		int startChk;
		int startErr;
		int i;
		testName = "resetIdle";
		startChk = checkCount;
		startErr = errCount;
		rstLevel = 1'b0;
		for (i = 0; i < 16; i++)
			runCycle(randBits(1) != 0, randBits(32), makeFlags());
		rstLevel = 1'b1;
		for (i = 0; i < 8; i++)
			runCycle(1'b0, randBits(32), makeFlags());
		reportTest(startChk, startErr);
	endtask

	// grp picks the encoding table, see makeInst
	task automatic runGroup(input string name, input int grp, input int count);
		int startChk;
		int startErr;
		int i;
		logic v;
		logic [31:0] word;
		cmpFlagsT flags;
		testName = name;
		startChk = checkCount;
		startErr = errCount;
		for (i = 0; i < count; i++) begin
			v = (randBits(3) != 32'd0);  // Idle about one slot in eight
			word = makeInst(grp);
			flags = makeFlags();
			runCycle(v, word, flags);
		end
		drainQueue();
		reportTest(startChk, startErr);
	endtask

	initial begin
		rst = 1'b0;
		instValid = 1'b0;
		inst = '0;
		cmp = '0;
		rstLevel = 1'b0;
		strobeHist = 2'b00;
		checkCount = 0;
		errCount = 0;
		lfsr = 32'hb950_20ac;
		resetIdle();
		runGroup("writeBack", 0, 400);
		runGroup("branchJump", 1, 300);
		runGroup("moves", 2, 100);
		runGroup("exceptions", 3, 300);
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- hw/ctrlTop.sv
`timescale 1ns/1ns

module ctrlTop (
	input  logic              clk,
	input  logic              rst,
	input  logic              instValid,
	input  ctrlPkg::instT     inst,
	input  ctrlPkg::cmpFlagsT cmp,
	output ctrlPkg::resultT   result,
	output logic              outValid
);
	import ctrlPkg::*;

	ctrlWordT decodeCtrl;  // Decode stage register
	cmpFlagsT cmpStage;
	logic     decValid;
	brOutT    brOut;       // Combinational, execute stage

	instDecoder instDecoder_inst (
		.clk        (clk),
		.rst        (rst),
		.instValid  (instValid),
		.inst       (inst),
		.cmp        (cmp),
		.decodeCtrl (decodeCtrl),
		.cmpStage   (cmpStage),
		.decValid   (decValid)
	);

	branchResolver branchResolver_inst (
		.decodeCtrl (decodeCtrl),
		.cmpStage   (cmpStage),
		.brOut      (brOut)
	);

	excPrioritizer excPrioritizer_inst (
		.clk        (clk),
		.rst        (rst),
		.decValid   (decValid),
		.decodeCtrl (decodeCtrl),
		.brOut      (brOut),
		.result     (result),
		.outValid   (outValid)
	);

endmodule

//--- hw/excPrioritizer.sv
`timescale 1ns/1ns

module excPrioritizer (
	input  logic              clk,
	input  logic              rst,
	input  logic              decValid,
	input  ctrlPkg::ctrlWordT decodeCtrl,
	input  ctrlPkg::brOutT    brOut,
	output ctrlPkg::resultT   result,
	output logic              outValid
);
	import ctrlPkg::*;

	resultT nextResult;

	always_comb begin
		nextResult.ctrl        = decodeCtrl.dp;
		nextResult.npcOp       = brOut.npcOp;
		nextResult.branchFlush = brOut.branchFlush;
		nextResult.moveCommit  = brOut.moveCommit;
		nextResult.exception   = 1'b1;

		// Reserved beats break, break beats syscall
		if (decodeCtrl.reserved)
			nextResult.excCode = ExcRi;
		else if (decodeCtrl.isBreak)
			nextResult.excCode = ExcBp;
		else if (decodeCtrl.isSyscall)
			nextResult.excCode = ExcSys;
		else begin
			nextResult.exception = 1'b0;
			nextResult.excCode   = ExcNone;
		end

		// Faulting instruction must not update any state
		if (nextResult.exception) begin
			nextResult.ctrl.rfWr    = 1'b0;
			nextResult.ctrl.dmWr    = 1'b0;
			nextResult.ctrl.hiloWr  = 1'b0;
			nextResult.ctrl.mdStart = 1'b0;
			nextResult.branchFlush  = 1'b0;
			nextResult.npcOp        = NpcSeq;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			outValid <= 1'b0;
			result   <= '0;
		end else begin
			outValid <= decValid;
			result   <= decValid ? nextResult : '0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		result.exception == (result.excCode != ExcNone))
		else $error("exception flag disagrees with excCode");

	// Result stage is exactly one cycle behind decode
	assert property (@(posedge clk) disable iff (!rst) decValid |=> outValid)
		else $error("outValid missing one cycle after decValid");

endmodule

//--- hw/branchResolver.sv
`timescale 1ns/1ns

module branchResolver (
	input  ctrlPkg::ctrlWordT decodeCtrl,
	input  ctrlPkg::cmpFlagsT cmpStage,
	output ctrlPkg::brOutT    brOut
);
	import ctrlPkg::*;

	logic condMet;
	logic moveBlocked;

	// Condition named by brType, from the rs/rt compare flags
	always_comb begin
		case (decodeCtrl.brType)
			BrEq:    condMet = cmpStage.rsEqRt;
			BrNe:    condMet = ~cmpStage.rsEqRt;
			BrGez:   condMet = (cmpStage.rsSign != SignNeg);
			BrLtz:   condMet = (cmpStage.rsSign == SignNeg);
			BrLez:   condMet = (cmpStage.rsSign != SignPos);
			BrGtz:   condMet = (cmpStage.rsSign == SignPos);
			default: condMet = 1'b0;  // Not a conditional branch
		endcase
	end

	// For moves the compare flag holds rt == 0
	// MOVZ fails when rt is nonzero, MOVN when rt is zero
	assign moveBlocked = decodeCtrl.isMove &&
		(decodeCtrl.moveOnZero != cmpStage.rsEqRt);

	always_comb begin
		if (condMet)
			brOut.npcOp = NpcBranch;
		else
			brOut.npcOp = decodeCtrl.jType;  // Jump, JumpReg, or Seq

		// Likely form not taken kills its delay slot
		brOut.branchFlush = decodeCtrl.likely && !condMet;
		brOut.moveCommit  = !moveBlocked;
	end

endmodule

//--- hw/instDecoder.sv
`timescale 1ns/1ns

module instDecoder (
	input  logic              clk,
	input  logic              rst,
	input  logic              instValid,
	input  ctrlPkg::instT     inst,
	input  ctrlPkg::cmpFlagsT cmp,
	output ctrlPkg::ctrlWordT decodeCtrl,
	output ctrlPkg::cmpFlagsT cmpStage,
	output logic              decValid
);
	import ctrlPkg::*;

	ctrlWordT dec;
	aluOpT    aluSel;  // Set only for forms that write an ALU result
	logic     memOp;

	always_comb begin
		dec = '0;
		dec.dp.aluOp = AluNone;
		dec.dp.wbSel = WbAlu;
		aluSel = AluNone;
		memOp = 1'b0;

		case (inst.i.op)
			OpRType: begin
				dec.dp.dstSel = DstRd;
				case (inst.r.funct)
					FnAdd:          aluSel = AluAdd;
					FnAddu:         aluSel = AluAddu;
					FnSub:          aluSel = AluSub;
					FnSubu:         aluSel = AluSubu;
					FnAnd:          aluSel = AluAnd;
					FnOr:           aluSel = AluOr;
					FnXor:          aluSel = AluXor;
					FnNor:          aluSel = AluNor;
					FnSlt:          aluSel = AluSlt;
					FnSltu:         aluSel = AluSltu;
					FnSll, FnSllv:  aluSel = AluSll;
					FnSrl, FnSrlv:  aluSel = AluSrl;
					FnSra, FnSrav:  aluSel = AluSra;
					FnMovz, FnMovn: begin
						aluSel = AluMov;
						dec.isMove = 1'b1;
						dec.moveOnZero = ~inst.r.funct[0];
					end
					FnJr: dec.jType = NpcJumpReg;
					FnJalr: begin
						dec.jType = NpcJumpReg;
						dec.dp.rfWr = 1'b1;
						dec.dp.wbSel = WbLink;  // Link into rd
					end
					FnMfhi, FnMflo: begin
						dec.dp.rfWr = 1'b1;
						dec.dp.wbSel = WbHilo;
						dec.dp.hiSel = ~inst.r.funct[1];
					end
					FnMthi, FnMtlo: begin
						dec.dp.hiloWr = 1'b1;
						dec.dp.hiSel = ~inst.r.funct[1];
					end
					FnMult, FnMultu, FnDiv, FnDivu: begin
						dec.dp.hiloWr = 1'b1;
						dec.dp.mdStart = 1'b1;
					end
					FnBreak:   dec.isBreak = 1'b1;
					FnSyscall: dec.isSyscall = 1'b1;
					default:   dec.reserved = 1'b1;
				endcase
				// SLL, SRL and SRA take shamt
				dec.dp.shamtSel = (inst.r.funct[5:2] == 4'b0000) && (aluSel != AluNone);
			end

			OpRegImm: begin
				case (inst.i.rt)
					RtBltz, RtBltzl, RtBltzal, RtBltzall: dec.brType = BrLtz;
					RtBgez, RtBgezl, RtBgezal, RtBgezall: dec.brType = BrGez;
					default: dec.reserved = 1'b1;
				endcase
				if (dec.brType != BrNone) begin
					dec.likely = inst.i.rt[1];
					if (inst.i.rt[4]) begin
						dec.dp.rfWr = 1'b1;
						dec.dp.dstSel = DstRa;
						dec.dp.wbSel = WbLink;
					end
				end
			end

			OpJ: dec.jType = NpcJump;
			OpJal: begin
				dec.jType = NpcJump;
				dec.dp.rfWr = 1'b1;
				dec.dp.dstSel = DstRa;
				dec.dp.wbSel = WbLink;
			end

			OpBeq, OpBeql: begin
				dec.brType = BrEq;
				dec.likely = inst.i.op[4];
			end
			OpBne, OpBnel: begin
				dec.brType = BrNe;
				dec.likely = inst.i.op[4];
			end
			OpBlez, OpBlezl: begin
				dec.brType = BrLez;
				dec.likely = inst.i.op[4];
			end
			OpBgtz, OpBgtzl: begin
				dec.brType = BrGtz;
				dec.likely = inst.i.op[4];
			end

			OpAddi: begin
				aluSel = AluAdd;
				dec.dp.extOp = ExtSign;
			end
			OpAddiu: begin
				aluSel = AluAddu;
				dec.dp.extOp = ExtSign;
			end
			OpSlti: begin
				aluSel = AluSlt;
				dec.dp.extOp = ExtSign;
			end
			OpSltiu: begin
				aluSel = AluSltu;
				dec.dp.extOp = ExtSign;
			end
			OpAndi: aluSel = AluAnd;  // Logical forms zero-extend
			OpOri:  aluSel = AluOr;
			OpXori: aluSel = AluXor;
			OpLui: begin
				dec.dp.rfWr = 1'b1;
				dec.dp.extOp = ExtUpper;
				dec.dp.wbSel = WbImm;
			end

			OpLb, OpSb: begin
				memOp = 1'b1;
				dec.dp.memSel = MemByte;
			end
			OpLbu: begin
				memOp = 1'b1;
				dec.dp.memSel = MemByteU;
			end
			OpLh, OpSh: begin
				memOp = 1'b1;
				dec.dp.memSel = MemHalf;
			end
			OpLhu: begin
				memOp = 1'b1;
				dec.dp.memSel = MemHalfU;
			end
			OpLwl, OpSwl: begin
				memOp = 1'b1;
				dec.dp.memSel = MemWordLeft;
			end
			OpLwr, OpSwr: begin
				memOp = 1'b1;
				dec.dp.memSel = MemWordRight;
			end
			OpLw, OpSw: begin
				memOp = 1'b1;
				dec.dp.memSel = MemWord;
			end

			default: dec.reserved = 1'b1;
		endcase

		if (aluSel != AluNone) begin
			dec.dp.rfWr = 1'b1;
			dec.dp.aluOp = aluSel;
		end

		// Address is rs plus sign-extended offset; op[3] splits store from load
		if (memOp) begin
			dec.dp.aluOp = AluAdd;
			dec.dp.extOp = ExtSign;
			dec.dp.wbSel = WbMem;
			dec.dp.dmWr = inst.i.op[3];
			dec.dp.dmRd = ~inst.i.op[3];
			dec.dp.rfWr = ~inst.i.op[3];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			decValid   <= 1'b0;
			decodeCtrl <= '0;
			cmpStage   <= '0;
		end else begin
			decValid   <= instValid;
			decodeCtrl <= instValid ? dec : '0;  // Idle slot carries no writes
			cmpStage   <= instValid ? cmp : '0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		!(decodeCtrl.dp.dmRd && decodeCtrl.dp.dmWr))
		else $error("decodeCtrl has both dmRd and dmWr set");

endmodule

//--- hw/ctrlPkg.sv
package ctrlPkg;

	// Primary opcodes, inst[31:26]
	localparam logic [5:0]
		OpRType = 6'b000000, OpRegImm = 6'b000001, OpJ = 6'b000010, OpJal = 6'b000011,
		OpBeq = 6'b000100, OpBne = 6'b000101, OpBlez = 6'b000110, OpBgtz = 6'b000111,
		OpAddi = 6'b001000, OpAddiu = 6'b001001, OpSlti = 6'b001010, OpSltiu = 6'b001011,
		OpAndi = 6'b001100, OpOri = 6'b001101, OpXori = 6'b001110, OpLui = 6'b001111,
		OpBeql = 6'b010100, OpBnel = 6'b010101, OpBlezl = 6'b010110, OpBgtzl = 6'b010111,
		OpLb = 6'b100000, OpLh = 6'b100001, OpLwl = 6'b100010, OpLw = 6'b100011,
		OpLbu = 6'b100100, OpLhu = 6'b100101, OpLwr = 6'b100110,
		OpSb = 6'b101000, OpSh = 6'b101001, OpSwl = 6'b101010, OpSw = 6'b101011,
		OpSwr = 6'b101110;

	// SPECIAL function field, inst[5:0]
	localparam logic [5:0]
		FnSll = 6'b000000, FnSrl = 6'b000010, FnSra = 6'b000011, FnSllv = 6'b000100,
		FnSrlv = 6'b000110, FnSrav = 6'b000111, FnJr = 6'b001000, FnJalr = 6'b001001,
		FnMovz = 6'b001010, FnMovn = 6'b001011, FnSyscall = 6'b001100, FnBreak = 6'b001101,
		FnMfhi = 6'b010000, FnMthi = 6'b010001, FnMflo = 6'b010010, FnMtlo = 6'b010011,
		FnMult = 6'b011000, FnMultu = 6'b011001, FnDiv = 6'b011010, FnDivu = 6'b011011,
		FnAdd = 6'b100000, FnAddu = 6'b100001, FnSub = 6'b100010, FnSubu = 6'b100011,
		FnAnd = 6'b100100, FnOr = 6'b100101, FnXor = 6'b100110, FnNor = 6'b100111,
		FnSlt = 6'b101010, FnSltu = 6'b101011;

	// REGIMM rt field; bit 1 marks likely, bit 4 marks link
	localparam logic [4:0]
		RtBltz = 5'b00000, RtBgez = 5'b00001, RtBltzl = 5'b00010, RtBgezl = 5'b00011,
		RtBltzal = 5'b10000, RtBgezal = 5'b10001, RtBltzall = 5'b10010, RtBgezall = 5'b10011;

	typedef enum logic [4:0] {
		AluAdd = 5'd0, AluSub = 5'd1, AluOr = 5'd2, AluAnd = 5'd3, AluNor = 5'd4,
		AluXor = 5'd5, AluSll = 5'd6, AluSrl = 5'd7, AluSra = 5'd8, AluSlt = 5'd9,
		AluSltu = 5'd10, AluMov = 5'd11, AluAddu = 5'd12, AluSubu = 5'd16, AluNone = 5'd31
	} aluOpT;

	typedef enum logic [1:0] {ExtZero = 2'd0, ExtSign = 2'd1, ExtUpper = 2'd2} extOpT;
	typedef enum logic [1:0] {DstRt = 2'd0, DstRd = 2'd1, DstRa = 2'd2} dstSelT;
	typedef enum logic [2:0] {
		WbHilo = 3'd0, WbImm = 3'd1, WbAlu = 3'd2, WbLink = 3'd3, WbMem = 3'd4
	} wbSelT;

	typedef enum logic [3:0] {
		MemByte = 4'd0, MemByteU = 4'd1, MemHalf = 4'd2, MemHalfU = 4'd3,
		MemWordLeft = 4'd4, MemWordRight = 4'd5, MemWord = 4'd6
	} memSelT;

	// Zero code is no branch, so an all-zero control word never branches
	typedef enum logic [2:0] {
		BrNone = 3'd0, BrEq = 3'd1, BrNe = 3'd2, BrGez = 3'd3,
		BrLtz = 3'd4, BrLez = 3'd5, BrGtz = 3'd6
	} brTypeT;

	typedef enum logic [1:0] {
		NpcSeq = 2'd0, NpcBranch = 2'd1, NpcJump = 2'd2, NpcJumpReg = 2'd3
	} npcOpT;

	typedef enum logic [1:0] {SignZero = 2'd0, SignPos = 2'd1, SignNeg = 2'd2} cmpSignT;
	typedef enum logic [4:0] {
		ExcNone = 5'd0, ExcSys = 5'd8, ExcBp = 5'd9, ExcRi = 5'd10
	} excCodeT;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormT;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFormT;

	typedef union packed {
		rFormT r;
		iFormT i;
	} instT;

	// Datapath part of the control word, carried through to the result
	typedef struct packed {
		logic    rfWr;
		dstSelT  dstSel;
		wbSelT   wbSel;
		aluOpT   aluOp;
		extOpT   extOp;
		logic    shamtSel;  // Shift amount from inst, not rs
		logic    dmRd;
		logic    dmWr;
		memSelT  memSel;
		logic    hiloWr;
		logic    hiSel;     // HI when set, LO otherwise
		logic    mdStart;
	} dpCtrlT;

	typedef struct packed {
		dpCtrlT  dp;
		brTypeT  brType;
		logic    likely;
		npcOpT   jType;     // NpcSeq when not a jump
		logic    isMove;
		logic    moveOnZero;
		logic    reserved;
		logic    isBreak;
		logic    isSyscall;
	} ctrlWordT;

	typedef struct packed {
		logic    rsEqRt;
		cmpSignT rsSign;
	} cmpFlagsT;

	// Execute-stage branch outcome
	typedef struct packed {
		npcOpT npcOp;
		logic  branchFlush;
		logic  moveCommit;
	} brOutT;

	typedef struct packed {
		dpCtrlT  ctrl;
		npcOpT   npcOp;
		logic    branchFlush;
		logic    moveCommit;
		logic    exception;
		excCodeT excCode;
	} resultT;

endpackage
